// ==== pad_top.f ====
logic/pad_pkg.sv
logic/nes_poller.sv
logic/pmod_receiver.sv
logic/pmod_decoder.sv
logic/pad_select.sv
logic/pad_top.sv
verif/pad_models.sv
verif/pad_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the pad testbench with verilator and runs it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pad_tb \
    -f pad_top.f -o pad_sim &&
./obj_dir/pad_sim || { echo "build or simulation failed"; exit 1; }

// ==== verif/pad_tb.sv ====
module pad_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int frame_limit = 4000; // one nes frame is about 2560 cycles
    localparam int send_limit  = 200;  // one adapter frame is about 100
    localparam int pin_limit   = 30;   // pin latch to buttons is 5

    logic                  clk;
    logic                  rst_n;
    logic                  nes_data;
    logic                  nes_latch;
    logic                  nes_clk;
    logic                  pmod_data;
    logic                  pmod_clk;
    logic                  pmod_latch;
    pad_pkg::pad_buttons_t buttons;
    logic                  snes_active;

    logic [7:0]            nes_pattern; // what the nes model loads at latch
    logic                  send_go;
    logic [11:0]           send_word;
    logic                  send_busy;

    // nes pin monitor
    logic                  latch_last   = 1'b0;
    logic                  clk_last     = 1'b0;
    logic                  seen_fall    = 1'b0; // first latch fall passed
    int                    latch_len    = 0;    // cycles with latch high
    int                    clk_rises    = 0;    // since last latch fall
    int                    latch_checks = 0;

    pad_top i_pad_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .pmod_data   (pmod_data),
        .pmod_clk    (pmod_clk),
        .pmod_latch  (pmod_latch),
        .buttons     (buttons),
        .snes_active (snes_active)
    );

    pad_models i_pad_models (
        .clk         (clk),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_pattern (nes_pattern),
        .nes_data    (nes_data),
        .send_go     (send_go),
        .send_word   (send_word),
        .send_busy   (send_busy),
        .pmod_data   (pmod_data),
        .pmod_clk    (pmod_clk),
        .pmod_latch  (pmod_latch)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    // model pattern bit 7 is a, shifted out first
    function automatic pad_pkg::pad_buttons_t nes_expected(input logic [7:0] p);
        pad_pkg::pad_buttons_t e;
        e        = '0;   // x, y, l, r stay 0
        e.a      = p[7];
        e.b      = p[6];
        e.select = p[5];
        e.start  = p[4];
        e.up     = p[3];
        e.down   = p[2];
        e.left   = p[1];
        e.right  = p[0];
        return e;
    endfunction

    // adapter word, b goes out first and r last
    function automatic pad_pkg::pad_buttons_t snes_expected(input logic [11:0] w);
        pad_pkg::pad_buttons_t e;
        e.b      = w[11];
        e.y      = w[10];
        e.select = w[9];
        e.start  = w[8];
        e.up     = w[7];
        e.down   = w[6];
        e.left   = w[5];
        e.right  = w[4];
        e.a      = w[3];
        e.x      = w[2];
        e.l      = w[1];
        e.r      = w[0];
        return e;
    endfunction

    task automatic expect_state(input pad_pkg::pad_buttons_t exp, input logic active);
        a_buttons: assert (buttons == exp) else begin
            $display("MISMATCH buttons got %h expected %h", buttons, exp);
            stop_run();
        end
        a_active: assert (snes_active == active) else begin
            $display("MISMATCH snes_active got %h expected %h", snes_active, active);
            stop_run();
        end
    endtask

    task automatic wait_latch_rise();
        logic last;
        logic seen;
        int   n;
        last = nes_latch;
        seen = 1'b0;
        n    = 0;
        while (!seen) begin
            @(negedge clk);
            seen = nes_latch && !last;
            last = nes_latch;
            n++;
            if (!seen && n > frame_limit) begin
                $display("timeout, nes_latch did not rise within %0d cycles", frame_limit);
                stop_run();
            end
        end
    endtask

    // one negedge first, model loads on the negedge of a latch rise
    task automatic apply_pattern(input logic [7:0] p);
        @(negedge clk);
        nes_pattern = p;
    endtask

    task automatic send_adapter(input logic [11:0] word);
        int n;
        n = 0;
        @(negedge clk);
        send_word = word;
        send_go   = 1'b1;
        @(negedge clk);   // model has taken it by now
        send_go = 1'b0;
        while (send_busy) begin
            @(negedge clk);
            n++;
            if (n > send_limit) begin
                $display("timeout, adapter sender still busy after %0d cycles", send_limit);
                stop_run();
            end
        end
    endtask

    task automatic wait_snes(input logic active, input pad_pkg::pad_buttons_t exp);
        int n;
        n = 0;
        while (!(snes_active == active && buttons == exp)) begin
            @(negedge clk);
            n++;
            if (n > pin_limit) begin
                $display("timeout, buttons did not follow the adapter frame");
                expect_state(exp, active); // shows which value is off
                stop_run();
            end
        end
        expect_state(exp, active);
    endtask

    // latch length and clock pulse count per nes frame
    always @(negedge clk) begin
        if (rst_n) begin
            if (nes_latch) begin
                latch_len++;
            end
            if (nes_clk && !clk_last) begin
                clk_rises++;
            end
            if (!nes_latch && latch_last) begin
                a_latch_len: assert (latch_len == pad_pkg::latch_cycles + 1) else begin
                    $display("MISMATCH nes_latch high cycles got %h expected %h",
                             latch_len, pad_pkg::latch_cycles + 1);
                    stop_run();
                end
                if (seen_fall) begin
                    a_clk_pulses: assert (clk_rises == 7) else begin
                        $display("MISMATCH nes_clk rises got %h expected %h", clk_rises, 7);
                        stop_run();
                    end
                end
                seen_fall = 1'b1;
                latch_len = 0;
                clk_rises = 0;
                latch_checks++;
            end
        end
        latch_last = nes_latch;
        clk_last   = nes_clk;
    end

    initial begin
        logic [31:0] rnd;
        logic [7:0]  pat;
        logic [11:0] word;
        int          k;
        rnd         = $urandom(32'h665e4525);
        clk         = 1'b0;
        rst_n       = 1'b0;
        nes_pattern = 8'h00;
        send_go     = 1'b0;
        send_word   = '0;

        // quiet outputs through reset
        repeat (16) begin
            @(negedge clk);
            a_reset_pins: assert (!nes_latch && !nes_clk) else begin
                $display("MISMATCH nes_latch/nes_clk got %h/%h expected 0/0",
                         nes_latch, nes_clk);
                stop_run();
            end
            expect_state('0, 1'b0);
        end
        rst_n = 1'b1;
        wait_latch_rise();
        expect_state('0, 1'b0); // no frame finished yet

        // nes only
        for (k = 0; k < 3; k++) begin
            rnd = $urandom();
            pat = rnd[7:0];
            apply_pattern(pat);
            wait_latch_rise();  // pad loads pat
            wait_latch_rise();  // that frame is out, buttons moved on this edge
            expect_state(nes_expected(pat), 1'b0);
        end

        // snes frame takes over
        rnd  = $urandom();
        word = rnd[11:0];
        if (word == 12'hfff) begin
            word = 12'hffe; // all ones reads as no pad
        end
        send_adapter(word);
        wait_snes(1'b1, snes_expected(word));
        rnd = $urandom();
        pat = rnd[7:0];
        apply_pattern(pat);
        wait_latch_rise();
        wait_latch_rise();
        expect_state(snes_expected(word), 1'b1); // nes frame ignored

        // pad unplugged, back to nes
        send_adapter(12'hfff);
        wait_snes(1'b0, nes_expected(pat));

        if (latch_checks < 5) begin
            $display("nes latch monitor saw only %0d frames", latch_checks);
            stop_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== verif/pad_models.sv ====
module pad_models (
    input  logic        clk,
    // nes controller side
    input  logic        nes_latch,
    input  logic        nes_clk,
    input  logic [7:0]  nes_pattern, // 1 = pressed, bit 7 = a down to bit 0 = right
    output logic        nes_data,    // low = pressed, like the real pad
    // adapter sender control
    input  logic        send_go,     // sampled on posedge, starts one frame
    input  logic [11:0] send_word,   // bit 11 goes out first
    output logic        send_busy,
    // adapter pins
    output logic        pmod_data,
    output logic        pmod_clk,
    output logic        pmod_latch
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 4; // adapter clock half period in clk cycles

    logic [7:0] pad_sr     = 8'h00; // parallel loaded at latch, a on top
    logic       latch_last = 1'b0;
    logic       clk_last   = 1'b0;

    initial begin
        send_busy  = 1'b0;
        pmod_data  = 1'b1;
        pmod_clk   = 1'b0;
        pmod_latch = 1'b0;
    end

    assign nes_data = ~pad_sr[7]; // active low pin

    // pad reacts to pin edges, seen on the falling clk edge
    always @(negedge clk) begin
        if (nes_latch && !latch_last) begin
            pad_sr = nes_pattern;              // load, a is on the pin now
        end else if (nes_clk && !clk_last) begin
            pad_sr = {pad_sr[6:0], 1'b0};      // next button, released fill
        end
        latch_last = nes_latch;
        clk_last   = nes_clk;
    end

    // one adapter frame, msb first, receiver takes data on pmod_clk rise
    task automatic send_frame(input logic [11:0] word);
        int i;
        send_busy = 1'b1;
        for (i = 11; i >= 0; i--) begin
            @(negedge clk);
            pmod_data = word[i];
            pmod_clk  = 1'b0;                      // low half
            repeat (half_period) @(negedge clk);
            pmod_clk = 1'b1;                       // high half
            repeat (half_period - 1) @(negedge clk);
        end
        @(negedge clk);
        pmod_clk   = 1'b0;
        pmod_latch = 1'b1;                         // frame strobe
        repeat (half_period) @(negedge clk);
        pmod_latch = 1'b0;
        @(posedge clk);
        send_busy = 1'b0;
    endtask

    always @(posedge clk) begin
        if (send_go) begin
            send_frame(send_word);
        end
    end

endmodule

// ==== logic/pad_top.sv ====
module pad_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // nes controller port
    input  logic                  nes_data,
    output logic                  nes_latch,
    output logic                  nes_clk,
    // snes adapter, three pins
    input  logic                  pmod_data,
    input  logic                  pmod_clk,
    input  logic                  pmod_latch,
    // merged state
    output pad_pkg::pad_buttons_t buttons,
    output logic                  snes_active  // 1 = snes pad in use
);

    // nes path
    pad_pkg::pad_buttons_t nes_buttons;
    logic                  nes_valid;

    // snes path, receiver then decoder
    pad_pkg::raw_frame_t   raw;
    logic                  raw_valid;
    pad_pkg::pad_buttons_t snes_buttons;
    logic                  snes_present;
    logic                  snes_valid;

    nes_poller i_nes_poller (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons),
        .nes_valid   (nes_valid)
    );

    pmod_receiver i_pmod_receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .raw        (raw),
        .raw_valid  (raw_valid)   // 3 cycles after pin latch rise
    );

    pmod_decoder i_pmod_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .raw          (raw),
        .raw_valid    (raw_valid),
        .snes_buttons (snes_buttons),
        .snes_present (snes_present),
        .snes_valid   (snes_valid)
    );

    // buttons move 1 cycle after either valid
    pad_select i_pad_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .nes_buttons  (nes_buttons),
        .nes_valid    (nes_valid),
        .snes_buttons (snes_buttons),
        .snes_present (snes_present),
        .snes_valid   (snes_valid),
        .buttons      (buttons),
        .snes_active  (snes_active)
    );

endmodule

// ==== logic/pad_select.sv ====
module pad_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pad_pkg::pad_buttons_t nes_buttons,
    input  logic                  nes_valid,
    input  pad_pkg::pad_buttons_t snes_buttons,
    input  logic                  snes_present,
    input  logic                  snes_valid,
    output pad_pkg::pad_buttons_t buttons,      // presented state
    output logic                  snes_active   // 1 = snes frame shown
);

    pad_pkg::pad_buttons_t nes_store;  // latest nes frame
    pad_pkg::pad_buttons_t snes_store; // latest snes frame
    logic                  snes_flag;  // presence of the latest snes frame

    // the two sources update independently, either may come any cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nes_store  <= '0;
            snes_store <= '0;
            snes_flag  <= 1'b0;
        end else begin
            if (nes_valid) begin
                nes_store <= nes_buttons; // poller holds x, y, l, r at 0
            end
            if (snes_valid) begin
                snes_store <= snes_buttons;
                snes_flag  <= snes_present;
            end
        end
    end

    assign buttons     = snes_flag ? snes_store : nes_store; // snes wins when present
    assign snes_active = snes_flag;

    // nes fallback never reports snes only buttons
    a_nes_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        !snes_active |-> !(buttons.x || buttons.y || buttons.l || buttons.r));

endmodule

// ==== logic/pmod_decoder.sv ====
module pmod_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pad_pkg::raw_frame_t   raw,          // frame from the receiver
    input  logic                  raw_valid,
    output pad_pkg::pad_buttons_t snes_buttons, // 1 = pressed
    output logic                  snes_present, // 0 when the frame was all ones
    output logic                  snes_valid    // raw_valid one cycle later
);

    logic                  absent;  // adapter sends all ones with no pad plugged
    pad_pkg::pad_buttons_t decoded;

    assign absent = (raw == '1);

    // bit 11 is b, down to bit 0 is r, same as the struct order
    assign decoded = absent ? '0 : pad_pkg::pad_buttons_t'(raw);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snes_valid   <= 1'b0;
            snes_present <= 1'b0;
        end else begin
            snes_valid <= raw_valid;
            if (raw_valid) begin
                snes_present <= ~absent;
            end
        end
    end

    // button payload, follows the valid
    always_ff @(posedge clk) begin
        if (raw_valid) begin
            snes_buttons <= decoded;
        end
    end

endmodule

// ==== logic/pmod_receiver.sv ====
module pmod_receiver (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pmod_data,  // async serial data from the adapter
    input  logic                pmod_clk,   // async shift clock, data taken on rise
    input  logic                pmod_latch, // async frame strobe
    output pad_pkg::raw_frame_t raw,        // last captured frame, all ones = no pad
    output logic                raw_valid   // one cycle per captured frame
);

    // two flop synchronizers, bit 1 is the safe side
    logic [1:0] data_sync;
    logic [1:0] clk_sync;
    logic [1:0] latch_sync;

    logic clk_prev;    // for edge detect on synced pmod_clk
    logic latch_prev;  // same for pmod_latch
    logic clk_rise;
    logic latch_rise;

    pad_pkg::raw_frame_t shift_reg; // newest bit at the low end

    assign clk_rise   = clk_sync[1] & ~clk_prev;
    assign latch_rise = latch_sync[1] & ~latch_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sync  <= 2'b00;
            clk_sync   <= 2'b00;
            latch_sync <= 2'b00;
        end else begin
            data_sync  <= {data_sync[0], pmod_data};
            clk_sync   <= {clk_sync[0], pmod_clk};
            latch_sync <= {latch_sync[0], pmod_latch};
        end
    end

    // capture runs only out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
            shift_reg  <= '1;  // reads as not present until a frame arrives
            raw        <= '1;
            raw_valid  <= 1'b0;
        end else begin
            clk_prev   <= clk_sync[1];
            latch_prev <= latch_sync[1];
            raw_valid  <= latch_rise; // pin rise to here is 3 cycles
            if (latch_rise) begin
                raw <= shift_reg;
            end
            if (clk_rise) begin
                shift_reg <= {shift_reg[pad_pkg::snes_bits-2:0], data_sync[1]};
            end
        end
    end

    // a latch edge needs the synced level to go low and high again
    a_raw_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        raw_valid |=> !raw_valid);

endmodule

// ==== logic/nes_poller.sv ====
module nes_poller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  nes_data,    // serial pad data, low = pressed
    output logic                  nes_latch,   // parallel load strobe to the pad
    output logic                  nes_clk,     // shift clock to the pad
    output pad_pkg::pad_buttons_t nes_buttons, // x, y, l, r always 0
    output logic                  nes_valid    // one cycle per polled frame
);

    pad_pkg::nes_state_t          state;
    pad_pkg::nes_state_t          state_next;
    pad_pkg::count_t              count;        // cycles spent in current state
    pad_pkg::count_t              end_count;    // last count of current state
    pad_pkg::count_t              sample_count; // count at which nes_data is taken
    logic                         state_done;
    logic                         sample_en;
    logic                         frame_end;    // read_right finishing
    logic [pad_pkg::nes_bits-1:0] sample_sr;    // a enters first, right last
    pad_pkg::pad_buttons_t        frame;

    // state length, the same rule for every read state
    always_comb begin
        case (state)
            pad_pkg::latch_en: end_count = pad_pkg::count_t'(pad_pkg::latch_cycles);
            pad_pkg::read_a:   end_count = pad_pkg::count_t'(pad_pkg::half_bit_cycles);
            default:           end_count = pad_pkg::count_t'(pad_pkg::bit_cycles);
        endcase
    end

    // a is already on the pin at latch, the rest mid pulse
    assign sample_count = (state == pad_pkg::read_a) ? '0 :
                          pad_pkg::count_t'(pad_pkg::half_bit_cycles);

    assign state_done = (count == end_count);
    assign sample_en  = (state != pad_pkg::latch_en) && (count == sample_count);
    assign frame_end  = state_done && (state == pad_pkg::read_right);

    // states are laid out in shift order, so next is just +1
    always_comb begin
        if (state >= pad_pkg::read_right) begin
            state_next = pad_pkg::latch_en; // wrap, also catches unused codes
        end else begin
            state_next = pad_pkg::nes_state_t'(state + 4'd1);
        end
    end

    // control path
    // pin outputs are registered from the current state, one cycle behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= pad_pkg::latch_en;
            count     <= '0;
            nes_latch <= 1'b0;
            nes_clk   <= 1'b0;
            nes_valid <= 1'b0;
        end else begin
            if (state_done) begin
                state <= state_next;
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            nes_latch <= (state == pad_pkg::latch_en);
            // pulse high for the first half of each read state after read_a
            nes_clk   <= (state != pad_pkg::latch_en) && (state != pad_pkg::read_a) &&
                         (count <= pad_pkg::count_t'(pad_pkg::half_bit_cycles));
            nes_valid <= frame_end;
        end
    end

    // pins are active low, flip to pressed = 1
    always_comb begin
        frame        = '0; // x, y, l, r do not exist on a nes pad
        frame.a      = ~sample_sr[7];
        frame.b      = ~sample_sr[6];
        frame.select = ~sample_sr[5];
        frame.start  = ~sample_sr[4];
        frame.up     = ~sample_sr[3];
        frame.down   = ~sample_sr[2];
        frame.left   = ~sample_sr[1];
        frame.right  = ~sample_sr[0];
    end

    // data path
    always_ff @(posedge clk) begin
        if (sample_en) begin
            sample_sr <= {sample_sr[pad_pkg::nes_bits-2:0], nes_data};
        end
        if (frame_end) begin
            nes_buttons <= frame; // right was sampled at mid pulse, all 8 are in
        end
    end

    // the pad would see a clock edge during parallel load
    a_latch_clk_excl: assert property (@(posedge clk) disable iff (!rst_n)
        nes_latch |-> !nes_clk);

endmodule

// ==== logic/pad_pkg.sv ====
package pad_pkg;

    // nes timing in clk cycles
    localparam int latch_cycles    = 300; // latch pulse, counted 0..latch_cycles
    localparam int bit_cycles      = 300; // one full nes clock period
    localparam int half_bit_cycles = 150; // sample point, nes_clk falls after it

    // frame sizes
    localparam int snes_bits = 12; // bits per adapter frame
    localparam int nes_bits  = 8;  // buttons on a nes pad

    typedef logic [10:0]          count_t;     // poller cycle counter, holds up to 300
    typedef logic [snes_bits-1:0] raw_frame_t; // adapter frame as shifted in

    // one bit per button, 1 = pressed
    // field order is the adapter bit order, msb first
    typedef struct packed {
        logic b;
        logic y;      // snes only
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic x;      // snes only
        logic l;      // snes only
        logic r;      // snes only
    } pad_buttons_t;

    // poller states
    // latch pulse first, then one state per nes button in shift order
    typedef enum logic [3:0] {
        latch_en,
        read_a,      // a is on the pin while latch is still high
        read_b,
        read_select,
        read_start,
        read_up,
        read_down,
        read_left,
        read_right   // last button, frame goes out when it ends
    } nes_state_t;

endpackage
